// File: logic/uart_frame_pkg.sv
/*
 * Shared constants and state types for the UART string link.
 * Import it inside a module body, or use scoped names in port lists.
 * Bit timing is short so that frames simulate quickly.
 */
package uart_frame_pkg;

	// serial bit timing
	localparam int clks_per_bit = 8;
	localparam int half_bit = clks_per_bit / 2;
	localparam int bit_cnt_w = $clog2(clks_per_bit);

	// byte k of a string bus sits at [8k+7:8k]
	localparam int max_bytes = 16;
	localparam int string_w = max_bytes * 8;
	localparam int len_w = 5;

	// two "&" open every frame and two close it
	localparam logic [7:0] frame_mark = 8'h26;

	typedef enum logic [1:0] {
		bit_idle,
		bit_start,
		bit_data,
		bit_stop
	} bit_state_t;

	typedef enum logic [2:0] {
		send_idle,
		send_head1,
		send_head2,
		send_body,
		send_tail1,
		send_tail2
	} send_state_t;

	typedef enum logic [1:0] {
		recv_hunt,
		recv_head2,
		recv_body,
		recv_tail2
	} recv_state_t;

endpackage

// File: logic/uart_tx.sv
/*
 * Byte-wide UART transmitter, 8N1, LSB first.
 * Pulse byte_req while idle; the line drops on the next cycle and
 * byte_done marks the last cycle of the stop bit.
 */
module uart_tx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_req,
	output logic       tx,
	output logic       byte_done
);
	import uart_frame_pkg::*;

	bit_state_t           state;
	logic [bit_cnt_w-1:0] cnt;
	logic [2:0]           idx;
	logic [7:0]           data_q;
	logic                 bit_end;

	assign bit_end = (cnt == bit_cnt_w'(clks_per_bit - 1));
	assign byte_done = (state == bit_stop) && bit_end;

	// byte is held for the whole frame
	always_ff @(posedge sys_clk) begin
		if (state == bit_idle && byte_req) begin
			data_q <= byte_data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= bit_idle;
			cnt <= '0;
			idx <= '0;
			tx <= 1'b1;
		end else begin
			cnt <= (state == bit_idle || bit_end) ? '0 : cnt + 1'b1;
			case (state)
				bit_idle: begin
					tx <= 1'b1;
					if (byte_req) begin
						state <= bit_start;
						tx <= 1'b0;
					end
				end
				bit_start: begin
					if (bit_end) begin
						state <= bit_data;
						idx <= '0;
						tx <= data_q[0];
					end
				end
				bit_data: begin
					if (bit_end) begin
						if (idx == 3'd7) begin
							state <= bit_stop;
							tx <= 1'b1;
						end else begin
							idx <= idx + 3'd1;
							tx <= data_q[idx + 3'd1];
						end
					end
				end
				default: begin
					// line is already high in the stop bit
					if (bit_end) begin
						state <= bit_idle;
					end
				end
			endcase
		end
	end

	a_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_done |=> !byte_done);

	a_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == bit_idle) |-> tx);

endmodule

// File: logic/uart_rx.sv
/*
 * Byte-wide UART receiver, 8N1, LSB first.
 * The line is synchronized, each bit is sampled at its middle and
 * rx_byte_vld pulses at mid stop bit when the stop bit is high.
 */
module uart_rx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_byte_vld
);
	import uart_frame_pkg::*;

	bit_state_t           state;
	logic [bit_cnt_w-1:0] cnt;
	logic [2:0]           idx;
	logic                 rx_meta;
	logic                 rx_sync;
	logic                 rx_prev;
	logic                 bit_end;
	logic                 half_end;

	assign bit_end = (cnt == bit_cnt_w'(clks_per_bit - 1));
	assign half_end = (cnt == bit_cnt_w'(half_bit - 1));

	// two-flop synchronizer plus one stage for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// shift register doubles as the output byte
	always_ff @(posedge sys_clk) begin
		if (state == bit_data && bit_end) begin
			rx_byte <= {rx_sync, rx_byte[7:1]};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= bit_idle;
			cnt <= '0;
			idx <= '0;
			rx_byte_vld <= 1'b0;
		end else begin
			rx_byte_vld <= 1'b0;
			cnt <= cnt + 1'b1;
			case (state)
				bit_idle: begin
					cnt <= '0;
					if (rx_prev && !rx_sync) begin
						state <= bit_start;
					end
				end
				bit_start: begin
					if (half_end) begin
						cnt <= '0;
						idx <= '0;
						// line back high means a glitch
						state <= rx_sync ? bit_idle : bit_data;
					end
				end
				bit_data: begin
					if (bit_end) begin
						cnt <= '0;
						idx <= idx + 3'd1;
						if (idx == 3'd7) begin
							state <= bit_stop;
						end
					end
				end
				default: begin
					if (bit_end) begin
						// framing error drops the byte
						rx_byte_vld <= rx_sync;
						state <= bit_idle;
					end
				end
			endcase
		end
	end

	a_vld_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_byte_vld |=> !rx_byte_vld);

endmodule

// File: logic/frame_sender.sv
/*
 * Wraps a parallel string as "&&payload&&" and feeds it to uart_tx
 * one byte at a time. String and length are captured on tx_req in
 * idle; tx_done pulses after the closing marker has gone out.
 */
module frame_sender (
	input  logic                                sys_clk,
	input  logic                                sys_rst_n,
	input  logic [uart_frame_pkg::string_w-1:0] tx_string,
	input  logic [uart_frame_pkg::len_w-1:0]    tx_length,
	input  logic                                tx_req,
	output logic                                tx_busy,
	output logic                                tx_done,
	output logic [7:0]                          byte_data,
	output logic                                byte_req,
	input  logic                                byte_done
);
	import uart_frame_pkg::*;

	send_state_t         state;
	logic [string_w-1:0] str_q;
	logic [len_w-1:0]    len_q;
	logic [len_w-1:0]    idx;

	// string and length held for the whole frame
	always_ff @(posedge sys_clk) begin
		if (state == send_idle && tx_req) begin
			str_q <= tx_string;
			len_q <= tx_length;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= send_idle;
			idx <= '0;
			tx_busy <= 1'b0;
			tx_done <= 1'b0;
			byte_data <= 8'h00;
			byte_req <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			tx_done <= 1'b0;
			case (state)
				send_idle: begin
					if (tx_req) begin
						state <= send_head1;
						tx_busy <= 1'b1;
						byte_data <= frame_mark;
						byte_req <= 1'b1;
					end
				end
				send_head1: begin
					if (byte_done) begin
						state <= send_head2;
						byte_data <= frame_mark;
						byte_req <= 1'b1;
					end
				end
				send_head2, send_body: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						// head2 always starts at byte 0
						if (state == send_head2 ? (len_q == '0) : (idx == len_q)) begin
							state <= send_tail1;
							byte_data <= frame_mark;
						end else if (state == send_head2) begin
							state <= send_body;
							byte_data <= str_q[7:0];
							idx <= len_w'(1);
						end else begin
							byte_data <= str_q[8 * idx +: 8];
							idx <= idx + 1'b1;
						end
					end
				end
				send_tail1: begin
					if (byte_done) begin
						state <= send_tail2;
						byte_data <= frame_mark;
						byte_req <= 1'b1;
					end
				end
				default: begin
					if (byte_done) begin
						state <= send_idle;
						tx_busy <= 1'b0;
						tx_done <= 1'b1;
					end
				end
			endcase
		end
	end

	a_len_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_busy |-> (len_q <= len_w'(max_bytes)));

	a_req_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> tx_busy);

endmodule

// File: logic/frame_receiver.sv
/*
 * Finds "&&payload&&" frames in the received byte stream.
 * Payload bytes are collected in a work buffer and copied to
 * rx_string/rx_length only when a clean trailer arrives.
 */
module frame_receiver (
	input  logic                                sys_clk,
	input  logic                                sys_rst_n,
	input  logic [7:0]                          rx_byte,
	input  logic                                rx_byte_vld,
	output logic [uart_frame_pkg::string_w-1:0] rx_string,
	output logic [uart_frame_pkg::len_w-1:0]    rx_length,
	output logic                                rx_busy,
	output logic                                rx_done,
	output logic                                rx_error
);
	import uart_frame_pkg::*;

	recv_state_t         state;
	logic [string_w-1:0] work_q;
	logic [len_w-1:0]    cnt;
	logic                is_mark;
	logic                full;

	assign is_mark = (rx_byte == frame_mark);
	assign full = (cnt == len_w'(max_bytes));

	// work buffer starts zeroed so unused bytes read back as zero
	always_ff @(posedge sys_clk) begin
		if (rx_byte_vld) begin
			if (state == recv_head2 && is_mark) begin
				work_q <= '0;
			end else if (state == recv_body && !is_mark && !full) begin
				work_q[8 * cnt +: 8] <= rx_byte;
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= recv_hunt;
			cnt <= '0;
			rx_busy <= 1'b0;
			rx_done <= 1'b0;
			rx_error <= 1'b0;
			rx_string <= '0;
			rx_length <= '0;
		end else begin
			rx_done <= 1'b0;
			rx_error <= 1'b0;
			if (rx_byte_vld) begin
				case (state)
					recv_hunt: begin
						if (is_mark) begin
							state <= recv_head2;
							rx_busy <= 1'b1;
						end
					end
					recv_head2: begin
						cnt <= '0;
						if (is_mark) begin
							state <= recv_body;
						end else begin
							// not a header after all
							state <= recv_hunt;
							rx_busy <= 1'b0;
						end
					end
					recv_body: begin
						if (is_mark) begin
							state <= recv_tail2;
						end else if (full) begin
							state <= recv_hunt;
							rx_busy <= 1'b0;
							rx_error <= 1'b1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					default: begin
						state <= recv_hunt;
						rx_busy <= 1'b0;
						if (is_mark) begin
							rx_done <= 1'b1;
							rx_string <= work_q;
							rx_length <= cnt;
						end else begin
							// lone '&' inside the payload
							rx_error <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	a_done_xor_err: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_error));

endmodule

// File: logic/uart_control.sv
/*
 * UART string link top level. Sends tx_string as "&&payload&&" on
 * uart_tx_port and reports frames found on uart_rx_port.
 */
module uart_control (
	input  logic                                sys_clk,
	input  logic                                sys_rst_n,

	input  logic [uart_frame_pkg::string_w-1:0] tx_string,
	input  logic [uart_frame_pkg::len_w-1:0]    tx_length,
	input  logic                                tx_req,
	output logic                                tx_busy,
	output logic                                tx_done,

	output logic [uart_frame_pkg::string_w-1:0] rx_string,
	output logic [uart_frame_pkg::len_w-1:0]    rx_length,
	output logic                                rx_busy,
	output logic                                rx_done,
	output logic                                rx_error,

	input  logic                                uart_rx_port,
	output logic                                uart_tx_port
);

	// sender to transmitter
	logic [7:0] byte_data;
	logic       byte_req;
	logic       byte_done;

	// receiver core to frame parser
	logic [7:0] rx_byte;
	logic       rx_byte_vld;

	frame_sender u_sender (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.tx        (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx          (uart_rx_port),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld)
	);

	frame_receiver u_receiver (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld),
		.rx_string   (rx_string),
		.rx_length   (rx_length),
		.rx_busy     (rx_busy),
		.rx_done     (rx_done),
		.rx_error    (rx_error)
	);

endmodule

// File: dv/uart_control_tb.sv
/*
 * Testbench for the UART string link. Tests come from dv/frame_vectors.txt.
 * Loopback tests send through the DUT's own transmitter, and raw tests
 * inject serial bytes directly. Each test ends by checking the receiver's report.
 */
module uart_control_tb;
	import uart_frame_pkg::*;

	logic                sys_clk;
	logic                sys_rst_n;
	logic [string_w-1:0] tx_string;
	logic [len_w-1:0]    tx_length;
	logic                tx_req;
	logic                tx_busy;
	logic                tx_done;
	logic [string_w-1:0] rx_string;
	logic [len_w-1:0]    rx_length;
	logic                rx_busy;
	logic                rx_done;
	logic                rx_error;
	logic                uart_tx_port;
	logic                raw_mode;
	logic                raw_line;

	// up to 32 tests of up to 24 bytes each
	logic [7:0]   vec_mode [0:31];
	int           vec_cnt [0:31];
	logic [191:0] vec_data [0:31];
	logic [7:0]   vec_out [0:31];
	int           vec_len [0:31];
	int           n_vec;
	logic         loaded;

	int                  errors;
	int                  passed;
	int                  tx_done_cnt;
	int                  rx_done_cnt;
	int                  rx_err_cnt;
	logic                rx_busy_seen;
	integer              seed;
	integer              fd;
	int                  t;
	logic [string_w-1:0] last_good;

	uart_control DUT (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (raw_mode ? raw_line : uart_tx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// count the one-cycle pulses at the rising edge
	always @(posedge sys_clk) begin
		if (tx_done) begin
			tx_done_cnt <= tx_done_cnt + 1;
		end
		if (rx_done) begin
			rx_done_cnt <= rx_done_cnt + 1;
		end
		if (rx_error) begin
			rx_err_cnt <= rx_err_cnt + 1;
		end
		if (rx_busy) begin
			rx_busy_seen <= 1'b1;
		end
	end

	initial begin
		longint limit;
		wait (loaded);
		limit = longint'(n_vec) * (max_bytes + 8) * 10 * clks_per_bit * 40 * 2;
		#(limit);
		$display("watchdog: the tests did not finish in %0d time units", limit);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic check_string(input logic [string_w-1:0] got,
		input logic [string_w-1:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_length(input logic [len_w-1:0] got, input logic [len_w-1:0] exp,
		input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Mismatch at %0t: %s counted %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic read_vectors();
		logic [7:0]       ch;
		logic [191:0]     row;
		logic [8*128-1:0] skip;
		int               b;
		int               cnt;
		int               k;
		int               code;
		n_vec = 0;
		code = $fscanf(fd, " %c", ch);
		while (code == 1 && n_vec < 32) begin
			if (ch == "#") begin
				code = $fgets(skip, fd);
			end else begin
				row = '0;
				vec_mode[n_vec] = ch;
				code = $fscanf(fd, "%d", cnt);
				vec_cnt[n_vec] = cnt;
				for (k = 0; k < cnt && k < 24; k++) begin
					code = $fscanf(fd, "%h", b);
					row[8 * k +: 8] = b[7:0];
				end
				vec_data[n_vec] = row;
				code = $fscanf(fd, " %c %d", ch, b);
				vec_out[n_vec] = ch;
				vec_len[n_vec] = b;
				n_vec++;
			end
			code = $fscanf(fd, " %c", ch);
		end
		$fclose(fd);
	endtask

	// one 8N1 byte followed by a random idle gap
	task automatic send_raw_byte(input logic [7:0] b);
		int i;
		int gap;
		raw_line = 1'b0;
		repeat (clks_per_bit) @(negedge sys_clk);
		for (i = 0; i < 8; i++) begin
			raw_line = b[i];
			repeat (clks_per_bit) @(negedge sys_clk);
		end
		raw_line = 1'b1;
		repeat (clks_per_bit) @(negedge sys_clk);
		gap = $unsigned($random(seed)) % 12;
		repeat (gap) @(negedge sys_clk);
	endtask

	task automatic run_test(input int t);
		logic [string_w-1:0] exp_str;
		logic [191:0]        row;
		logic [7:0]          mode;
		logic [7:0]          oc;
		int                  n;
		int                  k;
		int                  waited;
		int                  err_before;
		int                  tx_base;
		int                  done_base;
		int                  err_base;
		mode = vec_mode[t];
		oc = vec_out[t];
		n = vec_cnt[t];
		row = vec_data[t];
		err_before = errors;
		tx_base = tx_done_cnt;
		done_base = rx_done_cnt;
		err_base = rx_err_cnt;
		rx_busy_seen = 1'b0;
		exp_str = '0;
		if (mode == "L") begin
			raw_mode = 1'b0;
			for (k = 0; k < n; k++) begin
				exp_str[8 * k +: 8] = row[8 * k +: 8];
			end
			tx_string = exp_str;
			tx_length = len_w'(n);
			tx_req = 1'b1;
			@(negedge sys_clk);
			tx_req = 1'b0;
			repeat (3) @(negedge sys_clk);
			check_flag(tx_busy, 1'b1, "tx_busy during frame");
			// a request with other data while busy must be ignored
			tx_string = ~exp_str;
			tx_length = len_w'(3);
			tx_req = 1'b1;
			@(negedge sys_clk);
			tx_req = 1'b0;
		end else begin
			raw_mode = 1'b1;
			for (k = 0; k < n; k++) begin
				send_raw_byte(row[8 * k +: 8]);
			end
			// payload sits just before the closing "&&"
			for (k = 0; k < vec_len[t]; k++) begin
				exp_str[8 * k +: 8] = row[8 * (n - 2 - vec_len[t] + k) +: 8];
			end
		end
		waited = 0;
		if (oc != "N") begin
			while (waited < (max_bytes + 8) * 10 * clks_per_bit &&
				(rx_done_cnt + rx_err_cnt == done_base + err_base ||
				(mode == "L" && tx_done_cnt == tx_base))) begin
				@(negedge sys_clk);
				waited++;
			end
			if (mode == "L" && tx_done_cnt == tx_base) begin
				$display("timeout in test %0d: tx_done never came", t + 1);
				errors++;
			end
			if (rx_done_cnt + rx_err_cnt == done_base + err_base) begin
				$display("timeout in test %0d: neither rx_done nor rx_error came", t + 1);
				errors++;
			end
		end
		// settle two byte times so stray pulses get counted
		repeat (20 * clks_per_bit) @(negedge sys_clk);
		check_count(tx_done_cnt - tx_base, (mode == "L") ? 1 : 0, "tx_done");
		check_count(rx_done_cnt - done_base, (oc == "D") ? 1 : 0, "rx_done");
		check_count(rx_err_cnt - err_base, (oc == "E") ? 1 : 0, "rx_error");
		check_flag(rx_busy_seen, 1'b1, "rx_busy during frame");
		check_flag(tx_busy, 1'b0, "tx_busy after test");
		check_flag(rx_busy, 1'b0, "rx_busy after test");
		check_length(rx_length, len_w'(vec_len[t]), "rx_length");
		if (oc == "D") begin
			check_string(rx_string, exp_str, "rx_string");
			last_good = exp_str;
		end else begin
			check_string(rx_string, last_good, "rx_string kept");
		end
		if (errors == err_before) begin
			passed++;
		end
		$display("test %0d (%c, %0d bytes, expect %c): %s", t + 1, mode, n, oc,
			(errors == err_before) ? "pass" : "fail");
	endtask

	initial begin
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req = 1'b0;
		raw_mode = 1'b1;
		raw_line = 1'b1;
		seed = 86249;
		errors = 0;
		passed = 0;
		tx_done_cnt = 0;
		rx_done_cnt = 0;
		rx_err_cnt = 0;
		rx_busy_seen = 1'b0;
		last_good = '0;
		loaded = 1'b0;
		fd = $fopen("dv/frame_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/frame_vectors.txt for reading");
			$display("TESTS FAILED");
			$finish;
		end else begin
			read_vectors();
			loaded = 1'b1;
			repeat (8) @(negedge sys_clk);
			sys_rst_n = 1'b1;
			@(negedge sys_clk);
			check_flag(uart_tx_port, 1'b1, "uart_tx_port after reset");
			check_flag(tx_busy, 1'b0, "tx_busy after reset");
			check_flag(tx_done, 1'b0, "tx_done after reset");
			check_flag(rx_busy, 1'b0, "rx_busy after reset");
			check_flag(rx_done, 1'b0, "rx_done after reset");
			check_flag(rx_error, 1'b0, "rx_error after reset");
			check_length(rx_length, '0, "rx_length after reset");
			if (errors == 0) begin
				passed++;
			end
			$display("test 0 (reset state): %s", (errors == 0) ? "pass" : "fail");
			for (t = 0; t < n_vec; t++) begin
				run_test(t);
			end
			$display("%0d tests, %0d passed, %0d failed, %0d errors", n_vec + 1, passed,
				n_vec + 1 - passed, errors);
			if (errors == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

// File: dv/frame_vectors.txt
# mode count bytes(hex) outcome rx_length; outcome D done, E error, N no report
# mode L sends the bytes as payload in loopback, mode R injects them raw with markers
L 0 D 0
L 1 41 D 1
L 5 48 65 6c 6c 6f D 5
L 16 54 68 65 20 71 75 69 63 6b 20 66 6f 78 21 21 2e D 16
R 9 41 26 42 26 26 68 69 26 26 D 2
R 19 26 26 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f 40 E 2
R 5 26 26 61 26 62 E 2
R 3 55 26 aa N 2
R 4 26 26 26 26 D 0
L 3 78 79 7a D 3

// File: all.f
logic/uart_frame_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/frame_sender.sv
logic/frame_receiver.sv
logic/uart_control.sv
dv/uart_control_tb.sv
